/* include/exe_consts.svh */
`ifndef EXE_CONSTS_SVH
`define EXE_CONSTS_SVH

`define XLEN      64
`define REG_W     5
`define ALU_OP_W  5
`define BR_OP_W   4
`define SEL_W     2

// forwarding selects, ms has priority over ws
`define FWD_NONE  2'b00
`define FWD_WS    2'b01
`define FWD_MS    2'b10

`define ALU_ADD    5'd0
`define ALU_SUB    5'd1
`define ALU_SLL    5'd2
`define ALU_SLT    5'd3
`define ALU_SLTU   5'd4
`define ALU_XOR    5'd5
`define ALU_SRL    5'd6
`define ALU_SRA    5'd7
`define ALU_OR     5'd8
`define ALU_AND    5'd9
`define ALU_ADDW   5'd10   // word forms, sign-extended
`define ALU_SUBW   5'd11
`define ALU_SLLW   5'd12
`define ALU_SRLW   5'd13
`define ALU_SRAW   5'd14
`define ALU_PASS_B 5'd15   // lui

`define BR_NONE   4'd0
`define BR_BEQ    4'd1
`define BR_BNE    4'd2
`define BR_BLT    4'd3
`define BR_BGE    4'd4
`define BR_BLTU   4'd5
`define BR_BGEU   4'd6
`define BR_JAL    4'd7
`define BR_JALR   4'd8

`endif

/* rtl/exe_pkg.sv */
`include "exe_consts.svh"

package exe_pkg;

    typedef enum logic [`ALU_OP_W-1:0] {
        alu_add    = `ALU_ADD,
        alu_sub    = `ALU_SUB,
        alu_sll    = `ALU_SLL,
        alu_slt    = `ALU_SLT,
        alu_sltu   = `ALU_SLTU,
        alu_xor    = `ALU_XOR,
        alu_srl    = `ALU_SRL,
        alu_sra    = `ALU_SRA,
        alu_or     = `ALU_OR,
        alu_and    = `ALU_AND,
        alu_addw   = `ALU_ADDW,
        alu_subw   = `ALU_SUBW,
        alu_sllw   = `ALU_SLLW,
        alu_srlw   = `ALU_SRLW,
        alu_sraw   = `ALU_SRAW,
        alu_pass_b = `ALU_PASS_B
    } alu_op_e;

    typedef enum logic [`BR_OP_W-1:0] {
        br_none = `BR_NONE,
        br_beq  = `BR_BEQ,
        br_bne  = `BR_BNE,
        br_blt  = `BR_BLT,
        br_bge  = `BR_BGE,
        br_bltu = `BR_BLTU,
        br_bgeu = `BR_BGEU,
        br_jal  = `BR_JAL,
        br_jalr = `BR_JALR
    } br_op_e;

    typedef enum logic [`SEL_W-1:0] {a_reg, a_pc, a_zero} a_sel_e;

    typedef enum logic [`SEL_W-1:0] {b_reg, b_imm, b_four, b_zero} b_sel_e;  // four gives pc+4

    typedef struct packed {
        logic [`XLEN-1:0]  pc;
        logic [15:0]       inst_id;   // tag for tracking
        logic [`REG_W-1:0] rs1;
        logic [`REG_W-1:0] rs2;
        logic [`XLEN-1:0]  src1;
        logic [`XLEN-1:0]  src2;
        logic [`XLEN-1:0]  imm;
        alu_op_e           alu_op;
        a_sel_e            a_sel;
        b_sel_e            b_sel;
        br_op_e            br_op;
        logic              reg_wen;
        logic [`REG_W-1:0] rd;
    } de_bundle_t;

    typedef struct packed {
        logic [15:0]       inst_id;
        logic              reg_wen;
        logic [`REG_W-1:0] rd;
        logic [`XLEN-1:0]  result;
    } ms_bundle_t;

endpackage

/* rtl/alu.sv */
`timescale 1ns/1ps
`include "exe_consts.svh"

module alu (
    input  logic [`XLEN-1:0] a,
    input  logic [`XLEN-1:0] b,
    input  exe_pkg::alu_op_e op,
    output logic [`XLEN-1:0] result
);

    logic [5:0]  shamt;     // rv64 shift amount
    logic [4:0]  shamt_w;   // word shift amount
    logic [31:0] word_res;

    assign shamt   = b[5:0];
    assign shamt_w = b[4:0];

    // 32-bit result of the word forms
    always_comb begin
        case (op)
            exe_pkg::alu_addw: word_res = a[31:0] + b[31:0];
            exe_pkg::alu_subw: word_res = a[31:0] - b[31:0];
            exe_pkg::alu_sllw: word_res = a[31:0] << shamt_w;
            exe_pkg::alu_srlw: word_res = a[31:0] >> shamt_w;
            exe_pkg::alu_sraw: word_res = $signed(a[31:0]) >>> shamt_w;
            default:           word_res = '0;
        endcase
    end

    always_comb begin
        case (op)
            exe_pkg::alu_add:    result = a + b;
            exe_pkg::alu_sub:    result = a - b;
            exe_pkg::alu_sll:    result = a << shamt;
            exe_pkg::alu_slt:    result = {{(`XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            exe_pkg::alu_sltu:   result = {{(`XLEN-1){1'b0}}, a < b};
            exe_pkg::alu_xor:    result = a ^ b;
            exe_pkg::alu_srl:    result = a >> shamt;
            exe_pkg::alu_sra:    result = $signed(a) >>> shamt;
            exe_pkg::alu_or:     result = a | b;
            exe_pkg::alu_and:    result = a & b;
            exe_pkg::alu_addw,
            exe_pkg::alu_subw,
            exe_pkg::alu_sllw,
            exe_pkg::alu_srlw,
            exe_pkg::alu_sraw:   result = {{32{word_res[31]}}, word_res};  // sign extend
            exe_pkg::alu_pass_b: result = b;
            default:             result = '0;
        endcase
    end

endmodule

/* rtl/branch_unit.sv */
`timescale 1ns/1ps
`include "exe_consts.svh"

module branch_unit (
    input  logic [`XLEN-1:0] src1,
    input  logic [`XLEN-1:0] src2,
    input  logic [`XLEN-1:0] imm,
    input  logic [`XLEN-1:0] pc,
    input  exe_pkg::br_op_e  op,
    output logic             taken,
    output logic [`XLEN-1:0] target
);

    logic             eq;
    logic             lt_s;
    logic             lt_u;
    logic [`XLEN-1:0] pc_target;
    logic [`XLEN-1:0] jalr_target;

    assign eq   = (src1 == src2);
    assign lt_s = ($signed(src1) < $signed(src2));
    assign lt_u = (src1 < src2);

    assign pc_target   = pc + imm;
    assign jalr_target = (src1 + imm) & ~{{(`XLEN-1){1'b0}}, 1'b1};  // clear bit 0

    always_comb begin
        case (op)
            exe_pkg::br_beq:  taken = eq;
            exe_pkg::br_bne:  taken = !eq;
            exe_pkg::br_blt:  taken = lt_s;
            exe_pkg::br_bge:  taken = !lt_s;
            exe_pkg::br_bltu: taken = lt_u;
            exe_pkg::br_bgeu: taken = !lt_u;
            exe_pkg::br_jal,
            exe_pkg::br_jalr: taken = 1'b1;
            default:          taken = 1'b0;  // not a branch
        endcase
    end

    assign target = (op == exe_pkg::br_jalr) ? jalr_target : pc_target;

endmodule

/* rtl/forward_unit.sv */
`timescale 1ns/1ps
`include "exe_consts.svh"

module forward_unit (
    input  logic [`REG_W-1:0] rs1,
    input  logic [`REG_W-1:0] rs2,
    input  logic              ms_valid,
    input  logic              ws_valid,
    input  exe_pkg::ms_bundle_t ms_data,
    input  exe_pkg::ms_bundle_t ws_data,
    output logic [`SEL_W-1:0] fwd_a,
    output logic [`SEL_W-1:0] fwd_b
);

    logic ms_wr;   // ms will write a real register
    logic ws_wr;

    // x0 never forwards
    assign ms_wr = ms_valid && ms_data.reg_wen && (ms_data.rd != '0);
    assign ws_wr = ws_valid && ws_data.reg_wen && (ws_data.rd != '0);

    // younger stage wins
    assign fwd_a = (ms_wr && ms_data.rd == rs1) ? `FWD_MS :
                   (ws_wr && ws_data.rd == rs1) ? `FWD_WS : `FWD_NONE;

    assign fwd_b = (ms_wr && ms_data.rd == rs2) ? `FWD_MS :
                   (ws_wr && ws_data.rd == rs2) ? `FWD_WS : `FWD_NONE;

endmodule

/* rtl/pipe_stage.sv */
`timescale 1ns/1ps

module pipe_stage #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     in_valid,
    output logic     in_allowin,
    input  payload_t in_data,
    output logic     out_valid,
    input  logic     out_allowin,
    output payload_t out_data
);

    logic     valid_r;
    payload_t data_r;

    assign in_allowin = !valid_r || out_allowin;  // empty or draining
    assign out_valid  = valid_r;
    assign out_data   = data_r;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_r <= 1'b0;
        end else if (in_allowin) begin
            valid_r <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_allowin) begin
            data_r <= in_data;
        end
    end

endmodule

/* rtl/exe_stage.sv */
`timescale 1ns/1ps
`include "exe_consts.svh"

module exe_stage (
    input  logic                clk,
    input  logic                rst,
    input  logic                in_valid,
    output logic                in_allowin,
    input  exe_pkg::de_bundle_t in_data,
    input  logic [`SEL_W-1:0]   fwd_a,
    input  logic [`SEL_W-1:0]   fwd_b,
    input  logic [`XLEN-1:0]    ms_result,
    input  logic [`XLEN-1:0]    ws_result,
    output logic [`REG_W-1:0]   rs1,
    output logic [`REG_W-1:0]   rs2,
    output logic                out_valid,
    input  logic                out_allowin,
    output exe_pkg::ms_bundle_t out_data,
    output logic                redirect_valid,
    output logic [`XLEN-1:0]    redirect_pc
);

    logic                es_valid;
    exe_pkg::de_bundle_t es_r;
    logic [`XLEN-1:0]    fwd_src1;
    logic [`XLEN-1:0]    fwd_src2;
    logic [`XLEN-1:0]    alu_a;
    logic [`XLEN-1:0]    alu_b;
    logic [`XLEN-1:0]    alu_result;
    logic                br_taken;
    logic [`XLEN-1:0]    br_target;

    assign in_allowin = !es_valid || out_allowin;
    assign out_valid  = es_valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            es_valid <= 1'b0;
        end else if (in_allowin) begin
            es_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_allowin) begin
            es_r <= in_data;
        end
    end

    assign rs1 = es_r.rs1;  // to forward_unit
    assign rs2 = es_r.rs2;

    // pick forwarded sources first
    always_comb begin
        case (fwd_a)
            `FWD_MS: fwd_src1 = ms_result;
            `FWD_WS: fwd_src1 = ws_result;
            default: fwd_src1 = es_r.src1;
        endcase
        case (fwd_b)
            `FWD_MS: fwd_src2 = ms_result;
            `FWD_WS: fwd_src2 = ws_result;
            default: fwd_src2 = es_r.src2;
        endcase
    end

    // then the alu operands
    always_comb begin
        case (es_r.a_sel)
            exe_pkg::a_reg: alu_a = fwd_src1;
            exe_pkg::a_pc:  alu_a = es_r.pc;
            default:        alu_a = '0;
        endcase
        case (es_r.b_sel)
            exe_pkg::b_reg:  alu_b = fwd_src2;
            exe_pkg::b_imm:  alu_b = es_r.imm;
            exe_pkg::b_four: alu_b = `XLEN'd4;  // link value for jumps
            default:         alu_b = '0;
        endcase
    end

    alu u_alu (
        .a      (alu_a),
        .b      (alu_b),
        .op     (es_r.alu_op),
        .result (alu_result)
    );

    branch_unit u_branch (
        .src1   (fwd_src1),
        .src2   (fwd_src2),
        .imm    (es_r.imm),
        .pc     (es_r.pc),
        .op     (es_r.br_op),
        .taken  (br_taken),
        .target (br_target)
    );

    assign out_data.inst_id = es_r.inst_id;
    assign out_data.reg_wen = es_r.reg_wen;
    assign out_data.rd      = es_r.rd;
    assign out_data.result  = alu_result;

    // one pulse, on the edge the item moves to ms
    assign redirect_valid = es_valid && out_allowin && br_taken;
    assign redirect_pc    = br_target;

endmodule

/* rtl/exe_top.sv */
`timescale 1ns/1ps
`include "exe_consts.svh"

module exe_top (
    input  logic              clk,
    input  logic              rst,
    input  logic              in_valid,
    output logic              in_allowin,
    input  logic [`XLEN-1:0]  in_pc,
    input  logic [15:0]       in_inst_id,
    input  logic [`REG_W-1:0] in_rs1,
    input  logic [`REG_W-1:0] in_rs2,
    input  logic [`XLEN-1:0]  in_src1,
    input  logic [`XLEN-1:0]  in_src2,
    input  logic [`XLEN-1:0]  in_imm,
    input  exe_pkg::alu_op_e  in_alu_op,
    input  exe_pkg::a_sel_e   in_a_sel,
    input  exe_pkg::b_sel_e   in_b_sel,
    input  exe_pkg::br_op_e   in_br_op,
    input  logic              in_reg_wen,
    input  logic [`REG_W-1:0] in_rd,
    input  logic              wb_allowin,
    output logic              wb_valid,
    output logic [15:0]       wb_inst_id,
    output logic              wb_wen,
    output logic [`REG_W-1:0] wb_rd,
    output logic [`XLEN-1:0]  wb_data,
    output logic              redirect_valid,
    output logic [`XLEN-1:0]  redirect_pc
);

    exe_pkg::de_bundle_t de_data;
    exe_pkg::ms_bundle_t es_data;
    exe_pkg::ms_bundle_t ms_data;
    exe_pkg::ms_bundle_t ws_data;
    logic                es_valid;
    logic                ms_valid;
    logic                ws_valid;
    logic                ms_allowin;
    logic                ws_allowin;
    logic [`REG_W-1:0]   es_rs1;
    logic [`REG_W-1:0]   es_rs2;
    logic [`SEL_W-1:0]   fwd_a;
    logic [`SEL_W-1:0]   fwd_b;

    assign de_data = '{
        pc:      in_pc,
        inst_id: in_inst_id,
        rs1:     in_rs1,
        rs2:     in_rs2,
        src1:    in_src1,
        src2:    in_src2,
        imm:     in_imm,
        alu_op:  in_alu_op,
        a_sel:   in_a_sel,
        b_sel:   in_b_sel,
        br_op:   in_br_op,
        reg_wen: in_reg_wen,
        rd:      in_rd
    };

    exe_stage u_exe (
        .clk            (clk),
        .rst            (rst),
        .in_valid       (in_valid),
        .in_allowin     (in_allowin),
        .in_data        (de_data),
        .fwd_a          (fwd_a),
        .fwd_b          (fwd_b),
        .ms_result      (ms_data.result),
        .ws_result      (ws_data.result),
        .rs1            (es_rs1),
        .rs2            (es_rs2),
        .out_valid      (es_valid),
        .out_allowin    (ms_allowin),
        .out_data       (es_data),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

    pipe_stage #(.payload_t(exe_pkg::ms_bundle_t)) u_ms (
        .clk         (clk),
        .rst         (rst),
        .in_valid    (es_valid),
        .in_allowin  (ms_allowin),
        .in_data     (es_data),
        .out_valid   (ms_valid),
        .out_allowin (ws_allowin),
        .out_data    (ms_data)
    );

    pipe_stage #(.payload_t(exe_pkg::ms_bundle_t)) u_ws (
        .clk         (clk),
        .rst         (rst),
        .in_valid    (ms_valid),
        .in_allowin  (ws_allowin),
        .in_data     (ms_data),
        .out_valid   (ws_valid),
        .out_allowin (wb_allowin),
        .out_data    (ws_data)
    );

    forward_unit u_fwd (
        .rs1      (es_rs1),
        .rs2      (es_rs2),
        .ms_valid (ms_valid),
        .ws_valid (ws_valid),
        .ms_data  (ms_data),
        .ws_data  (ws_data),
        .fwd_a    (fwd_a),
        .fwd_b    (fwd_b)
    );

    // retire port
    assign wb_valid   = ws_valid;
    assign wb_inst_id = ws_data.inst_id;
    assign wb_wen     = ws_data.reg_wen;
    assign wb_rd      = ws_data.rd;
    assign wb_data    = ws_data.result;

endmodule

/* tb/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock #(
    parameter int HALF_NS = 2   // 4 ns period
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(HALF_NS) clk = ~clk;
    end

endmodule

/* tb/exe_top_sva.sv */
`timescale 1ns/1ps
`include "exe_consts.svh"

module exe_top_sva (
    input logic              clk,
    input logic              rst,
    input logic              wb_valid,
    input logic              wb_allowin,
    input logic              wb_wen,
    input logic [`REG_W-1:0] wb_rd,
    input logic [`XLEN-1:0]  wb_data,
    input logic              redirect_valid
);

    a_quiet_after_reset: assert property (@(posedge clk) rst |=> !wb_valid && !redirect_valid)
        else $error("retire or redirect active in the cycle after reset");

    // retire item must hold while the consumer stalls
    a_hold_under_stall: assert property (@(posedge clk) disable iff (rst)
        wb_valid && !wb_allowin |=> wb_valid && $stable(wb_data))
        else $error("retire data changed while held");

    a_no_x0_write: assert property (@(posedge clk) disable iff (rst)
        wb_valid && wb_wen |-> wb_rd != '0)
        else $error("retire writes register x0");

endmodule

bind exe_top exe_top_sva u_sva (
    .clk            (clk),
    .rst            (rst),
    .wb_valid       (wb_valid),
    .wb_allowin     (wb_allowin),
    .wb_wen         (wb_wen),
    .wb_rd          (wb_rd),
    .wb_data        (wb_data),
    .redirect_valid (redirect_valid)
);

/* tb/exe_top_tb.sv */
`timescale 1ns/1ps
`include "exe_consts.svh"

module exe_top_tb;

    localparam int NUM_INSTR  = 600;
    localparam int FREE_INSTR = 200;    // no back-pressure while issuing these
    localparam int MAX_CYCLES = 20000;
    localparam int NUM_REGS   = 6;      // few registers, many dependencies

    typedef struct packed {
        logic [15:0]       id;
        logic              wen;
        logic [`REG_W-1:0] rd;
        logic [`XLEN-1:0]  res;
    } retire_t;

    logic clk;
    logic rst;
    logic in_valid;
    logic in_allowin;
    logic [`XLEN-1:0]  in_pc;
    logic [15:0]       in_inst_id;
    logic [`REG_W-1:0] in_rs1;
    logic [`REG_W-1:0] in_rs2;
    logic [`XLEN-1:0]  in_src1;
    logic [`XLEN-1:0]  in_src2;
    logic [`XLEN-1:0]  in_imm;
    exe_pkg::alu_op_e  in_alu_op;
    exe_pkg::a_sel_e   in_a_sel;
    exe_pkg::b_sel_e   in_b_sel;
    exe_pkg::br_op_e   in_br_op;
    logic              in_reg_wen;
    logic [`REG_W-1:0] in_rd;
    logic              wb_allowin;
    logic              wb_valid;
    logic [15:0]       wb_inst_id;
    logic              wb_wen;
    logic [`REG_W-1:0] wb_rd;
    logic [`XLEN-1:0]  wb_data;
    logic              redirect_valid;
    logic [`XLEN-1:0]  redirect_pc;

    integer              seed;
    int                  cyc;
    int                  issued;
    int                  in_flight;
    int                  last_stall;    // last cycle the consumer held back
    logic                pending;       // pend is offered but not yet taken
    logic                wb_next;       // wb_allowin for the coming cycle
    exe_pkg::de_bundle_t pend;
    logic [`XLEN-1:0]    arch_rf [32];  // program order state
    logic [`XLEN-1:0]    ret_rf [32];   // retired state, feeds src1/src2
    retire_t             exp_ret_q [$];
    int                  acc_q [$];
    logic [`XLEN-1:0]    redir_q [$];

    tb_clock u_clock (.clk(clk));

    exe_top uut (.*);

    function automatic logic [31:0] rand32();
        return $random(seed);
    endfunction

    function automatic logic [31:0] rand_below(input int n);
        logic [31:0] r;
        r = rand32();
        return r % 32'(n);
    endfunction

    function automatic logic [63:0] sext32(input logic [31:0] w);
        return {{32{w[31]}}, w};
    endfunction

    function automatic logic [63:0] alu_model(input logic [4:0] op, input logic [63:0] a,
                                              input logic [63:0] b);
        logic [31:0] aw;
        logic [31:0] bw;
        logic [63:0] fill;
        logic [31:0] fill_w;
        aw = a[31:0];
        bw = b[31:0];
        fill = a[63] ? ~(64'hffff_ffff_ffff_ffff >> b[5:0]) : 64'd0;  // sign bits for sra
        fill_w = aw[31] ? ~(32'hffff_ffff >> b[4:0]) : 32'd0;
        case (op)
            `ALU_ADD:    return a + b;
            `ALU_SUB:    return a - b;
            `ALU_SLL:    return a << b[5:0];
            `ALU_SLT:    return {63'd0, (a[63] != b[63]) ? a[63] : (a < b)};
            `ALU_SLTU:   return {63'd0, a < b};
            `ALU_XOR:    return a ^ b;
            `ALU_SRL:    return a >> b[5:0];
            `ALU_SRA:    return (a >> b[5:0]) | fill;
            `ALU_OR:     return a | b;
            `ALU_AND:    return a & b;
            `ALU_ADDW:   return sext32(aw + bw);
            `ALU_SUBW:   return sext32(aw - bw);
            `ALU_SLLW:   return sext32(aw << b[4:0]);
            `ALU_SRLW:   return sext32(aw >> b[4:0]);
            `ALU_SRAW:   return sext32((aw >> b[4:0]) | fill_w);
            `ALU_PASS_B: return b;
            default:     return 64'd0;
        endcase
    endfunction

    function automatic logic taken_model(input logic [3:0] op, input logic [63:0] x,
                                         input logic [63:0] y);
        logic ltu;
        logic lt;
        ltu = x < y;
        lt = (x[63] != y[63]) ? x[63] : ltu;
        case (op)
            `BR_BEQ:           return x == y;
            `BR_BNE:           return x != y;
            `BR_BLT:           return lt;
            `BR_BGE:           return !lt;
            `BR_BLTU:          return ltu;
            `BR_BGEU:          return !ltu;
            `BR_JAL, `BR_JALR: return 1'b1;
            default:           return 1'b0;
        endcase
    endfunction

    // register file read with write-first bypass of the next retire
    function automatic logic [`XLEN-1:0] rf_read(input logic [`REG_W-1:0] idx,
                                                  input logic retire_next);
        retire_t o;
        if (retire_next && acc_q.size() != 0 && exp_ret_q.size() != 0) begin
            o = exp_ret_q[0];
            // oldest item sits in ws two edges after it was taken
            if (cyc - acc_q[0] >= 2 && o.wen && o.rd == idx) begin
                return o.res;
            end
        end
        return ret_rf[idx];
    endfunction

    task automatic stop_run(input string why);
        $display("ERROR at %0t ns: %s", $time, why);
        $display("TEST RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %0t ns %s got %h expected %h", $time, name, got, exp);
            $display("TEST RESULT: FAIL");
            $fatal(1);
        end
    endtask

    // new instruction in program order, expectations computed here
    task automatic gen_instr();
        logic [31:0]      r;
        logic [3:0]       br;
        logic [`XLEN-1:0] s1;
        logic [`XLEN-1:0] s2;
        logic [`XLEN-1:0] op_a;
        logic [`XLEN-1:0] op_b;
        retire_t          e;
        r = rand32();
        br = (rand_below(3) == 0) ? 4'(32'd1 + rand_below(8)) : `BR_NONE;
        pend.pc = {rand32(), rand32()} & ~64'd3;
        pend.inst_id = 16'(issued);
        pend.rs1 = 5'(rand_below(NUM_REGS));
        pend.rs2 = 5'(rand_below(NUM_REGS));
        pend.rd = 5'(rand_below(NUM_REGS));
        pend.imm = r[31] ? {{52{r[11]}}, r[11:0]} : {rand32(), r};  // short or wide immediate
        pend.alu_op = exe_pkg::alu_op_e'(5'(rand_below(16)));
        pend.a_sel = exe_pkg::a_sel_e'(2'(rand_below(3)));
        pend.b_sel = exe_pkg::b_sel_e'(2'(rand_below(4)));
        pend.br_op = exe_pkg::br_op_e'(br);
        pend.reg_wen = (br == `BR_NONE) ? (rand_below(8) != 0) : 1'b0;
        if (br == `BR_JAL || br == `BR_JALR) begin
            pend.alu_op = exe_pkg::alu_add;  // link value pc+4
            pend.a_sel = exe_pkg::a_pc;
            pend.b_sel = exe_pkg::b_four;
            pend.reg_wen = 1'b1;
        end
        if (pend.rd == '0) begin
            pend.reg_wen = 1'b0;  // decoder drops writes to x0
        end
        s1 = arch_rf[pend.rs1];
        s2 = arch_rf[pend.rs2];
        case (pend.a_sel)
            exe_pkg::a_reg: op_a = s1;
            exe_pkg::a_pc:  op_a = pend.pc;
            default:        op_a = '0;
        endcase
        case (pend.b_sel)
            exe_pkg::b_reg:  op_b = s2;
            exe_pkg::b_imm:  op_b = pend.imm;
            exe_pkg::b_four: op_b = 64'd4;
            default:         op_b = '0;
        endcase
        e = '{pend.inst_id, pend.reg_wen, pend.rd, alu_model(pend.alu_op, op_a, op_b)};
        exp_ret_q.push_back(e);
        if (taken_model(br, s1, s2)) begin
            redir_q.push_back((br == `BR_JALR) ? ((s1 + pend.imm) & ~64'd1) : pend.pc + pend.imm);
        end
        if (e.wen) begin
            arch_rf[e.rd] = e.res;
        end
        pending = 1'b1;
        issued++;
    endtask

    task automatic drive_inputs(input logic retire_next);
        in_valid   <= pending;
        in_pc      <= pend.pc;
        in_inst_id <= pend.inst_id;
        in_rs1     <= pend.rs1;
        in_rs2     <= pend.rs2;
        in_src1    <= rf_read(pend.rs1, retire_next);  // includes the write on the sampling edge
        in_src2    <= rf_read(pend.rs2, retire_next);
        in_imm     <= pend.imm;
        in_alu_op  <= pend.alu_op;
        in_a_sel   <= pend.a_sel;
        in_b_sel   <= pend.b_sel;
        in_br_op   <= pend.br_op;
        in_reg_wen <= pend.reg_wen;
        in_rd      <= pend.rd;
    endtask

    task automatic take_retire();
        retire_t e;
        int      acc;
        if (in_flight == 0) begin
            stop_run("retire seen with no instruction in flight");
        end else begin
            e = exp_ret_q.pop_front();
            acc = acc_q.pop_front();
            check("wb_inst_id", 64'(wb_inst_id), 64'(e.id));
            check("wb_wen", 64'(wb_wen), 64'(e.wen));
            check("wb_rd", 64'(wb_rd), 64'(e.rd));
            check("wb_data", wb_data, e.res);
            if (last_stall <= acc) begin
                check("retire latency", 64'(cyc - acc), 64'd3);
            end else if (cyc - acc < 3) begin
                stop_run("instruction retired in under three cycles");
            end
            if (e.wen) begin
                ret_rf[e.rd] = e.res;
            end
            in_flight--;
        end
    endtask

    initial begin
        seed = 32'hd2986158;
        cyc = 0;
        issued = 0;
        in_flight = 0;
        last_stall = 0;
        pending = 1'b0;
        wb_next = 1'b1;
        pend = '0;
        arch_rf[0] = '0;
        ret_rf[0] = '0;
        for (int i = 1; i < 32; i++) begin
            arch_rf[i] = {rand32(), rand32()};
            ret_rf[i] = arch_rf[i];
        end
        rst <= 1'b1;
        wb_allowin <= 1'b1;
        drive_inputs(1'b1);
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        check("wb_valid", 64'(wb_valid), 64'd0);
        check("redirect_valid", 64'(redirect_valid), 64'd0);
        check("in_allowin", 64'(in_allowin), 64'd1);
        while (issued < NUM_INSTR || pending || in_flight != 0) begin
            @(posedge clk);
            cyc++;
            if (cyc > MAX_CYCLES) begin
                stop_run("timeout, pipeline did not drain");
            end
            if (!wb_allowin) begin
                last_stall = cyc;
            end
            // full only when three items sit in the pipe and the consumer stalls
            check("in_allowin", 64'(in_allowin), 64'((in_flight < 3) || wb_allowin));
            if (wb_valid && wb_allowin) begin
                take_retire();
            end
            if (redirect_valid) begin
                if (redir_q.size() == 0) begin
                    stop_run("redirect seen for an instruction that is not taken");
                end else begin
                    check("redirect_pc", redirect_pc, redir_q.pop_front());
                end
            end
            if (in_valid && in_allowin) begin
                pending = 1'b0;
                in_flight++;
                acc_q.push_back(cyc);
            end
            if (!pending && issued < NUM_INSTR && rand_below(4) != 0) begin
                gen_instr();
            end
            wb_next = (issued < FREE_INSTR) ? 1'b1 : (rand_below(3) != 0);
            drive_inputs(wb_next);
            wb_allowin <= wb_next;
        end
        if (exp_ret_q.size() == 0 && redir_q.size() == 0) begin
            $display("TEST RESULT: PASS");
            $finish;
        end else begin
            stop_run("expected retires or redirects never appeared");
        end
    end

endmodule

/* sources.f */
+incdir+include
rtl/exe_pkg.sv
rtl/alu.sv
rtl/branch_unit.sv
rtl/forward_unit.sv
rtl/pipe_stage.sv
rtl/exe_stage.sv
rtl/exe_top.sv
tb/tb_clock.sv
tb/exe_top_sva.sv
tb/exe_top_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= exe_top_tb
SEED_ARGS ?=
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP SEED_ARGS BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -Mdir $(BUILD_DIR) --top-module $(TOP) -f sources.f
	@out="$$(./$(BUILD_DIR)/V$(TOP) $(SEED_ARGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST RESULT: PASS"

clean:
	rm -rf $(BUILD_DIR)
